/* uart_cases.txt */
# columns: op addr data expect, all hex; addr 0 data, 1 status, 2 config
# W write data; R read, status compared under the data mask; P poll until (status & data) == expect; I irq level in expect bit 0
# reset state and empty read
R 1 007f 0009
I 0 0000 0000
R 0 0000 0000
R 1 007f 0009
# loopback at baud_div 3
W 2 0300 0000
W 0 00a5 0000
W 0 003c 0000
W 0 0081 0000
P 1 0008 0000
R 0 0000 00a5
P 1 0008 0000
R 0 0000 003c
P 1 0008 0000
R 0 0000 0081
# nine writes at baud_div 7, RX keeps eight
W 2 0700 0000
W 0 0001 0000
W 0 0002 0000
W 0 0003 0000
W 0 0004 0000
W 0 0005 0000
W 0 0006 0000
W 0 0007 0000
W 0 0008 0000
W 0 0009 0000
R 1 0002 0002
P 1 0041 0001
R 1 0018 0010
R 0 0000 0001
R 0 0000 0002
R 0 0000 0003
R 0 0000 0004
R 0 0000 0005
R 0 0000 0006
R 0 0000 0007
R 0 0000 0008
R 0 0000 0000
R 1 0018 0008
# rx_level 3 with rx irq enabled
W 2 070d 0000
W 0 0011 0000
W 0 0022 0000
W 0 0033 0000
P 1 0041 0001
I 0 0000 0000
R 1 0020 0000
W 0 0044 0000
P 1 0020 0020
I 0 0000 0001
R 0 0000 0011
I 0 0000 0000
R 1 0020 0000
R 0 0000 0022
R 0 0000 0033
R 0 0000 0044
# tx_level 2 with tx irq enabled
W 2 0742 0000
I 0 0000 0001
W 0 0055 0000
W 0 0066 0000
W 0 0077 0000
W 0 0088 0000
R 1 0004 0000
I 0 0000 0000
P 1 0004 0004
I 0 0000 0001
P 1 0041 0001
R 0 0000 0055
R 0 0000 0066
R 0 0000 0077
R 0 0000 0088
R 1 007f 000d

/* filelist.f */
uart_fifo_pkg.sv
uart_reg_pkg.sv
sync_fifo.sv
uart_tx_shift.sv
uart_rx_shift.sv
uart_regs.sv
uart_core.sv
tb_uart_core.sv

/* Bender.yml */
package:
  name: uart_core

sources:
  - uart_fifo_pkg.sv
  - uart_reg_pkg.sv
  - sync_fifo.sv
  - uart_tx_shift.sv
  - uart_rx_shift.sv
  - uart_regs.sv
  - uart_core.sv
  - target: simulation
    files:
      - tb_uart_core.sv

/* tb_uart_core.sv */
// self-checking testbench for uart_core, replays uart_cases.txt over a tx to rx loopback
`timescale 1ns/1ns

module tb_uart_core;
  import uart_reg_pkg::*;

  // status reads allowed per poll before giving up
  localparam int poll_limit = 1000;

  logic                  clock;
  logic                  rst;
  logic                  sel;
  logic                  wr;
  logic [reg_addr_w-1:0] addr;
  logic [reg_word_w-1:0] wdata;
  logic [reg_word_w-1:0] rdata;
  logic                  irq;
  logic                  tx_line;
  logic                  rx_line;
  logic                  loop_en;

  integer seed;
  int     errors;
  int     ncases;
  int     nfail;
  bit     case_bad;
  bit     abort;

  // loopback, line idles high until reset is released
  assign rx_line = loop_en ? tx_line : 1'b1;

  uart_core u_dut (
    .clock(clock), .rst(rst), .sel(sel), .wr(wr), .addr(addr), .wdata(wdata),
    .rx(rx_line), .rdata(rdata), .irq(irq), .tx(tx_line)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // one write strobe after a random idle gap
  task automatic write_reg(input logic [reg_addr_w-1:0] a, input logic [reg_word_w-1:0] d);
    int gap;
    gap = {$random(seed)} % 4;
    repeat (gap) @(posedge clock);
    @(posedge clock);
    sel   <= 1'b1;
    wr    <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge clock);
    sel <= 1'b0;
    wr  <= 1'b0;
  endtask

  // rdata is registered, sampled mid-cycle after the strobe edge
  task automatic read_reg(input logic [reg_addr_w-1:0] a, output uart_word_u val);
    @(posedge clock);
    sel  <= 1'b1;
    wr   <= 1'b0;
    addr <= a;
    @(posedge clock);
    sel <= 1'b0;
    @(negedge clock);
    val = rdata;
  endtask

  task automatic check_data(input uart_word_u got, input uart_word_u want);
    if (got.dat !== want.dat) begin
      $display("CHECK FAILED at %0t: data read %h, expected %h", $time, got, want);
      errors++;
      case_bad = 1'b1;
    end
  endtask

  // only bits under mask are compared
  task automatic check_status(input uart_word_u got, input uart_word_u want,
                              input logic [reg_word_w-1:0] mask);
    if ((got & mask) !== (want & mask)) begin
      $display("CHECK FAILED at %0t: status %h, expected %h under mask %h",
               $time, got, want, mask);
      errors++;
      case_bad = 1'b1;
    end
  endtask

  task automatic check_irq(input logic got, input logic want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: irq %b, expected %b", $time, got, want);
      errors++;
      case_bad = 1'b1;
    end
  endtask

  // repeated status reads until the masked bits match
  task automatic poll_status(input logic [reg_addr_w-1:0] a, input logic [reg_word_w-1:0] mask,
                             input logic [reg_word_w-1:0] want, output bit ok);
    uart_word_u val;
    int         tries;
    ok    = 1'b0;
    tries = 0;
    while (!ok && tries < poll_limit) begin
      read_reg(a, val);
      ok = ((val & mask) === (want & mask));
      tries++;
    end
    if (!ok) begin
      $display("timeout at %0t: status never reached %h under mask %h within %0d reads",
               $time, want, mask, poll_limit);
    end
  endtask

  task automatic run_case(input string op, input logic [reg_addr_w-1:0] a,
                          input logic [reg_word_w-1:0] d, input logic [reg_word_w-1:0] e);
    uart_word_u val;
    bit         ok;
    case_bad = 1'b0;
    if (op == "W") begin
      write_reg(a, d);
    end else if (op == "R") begin
      read_reg(a, val);
      // data column is the compare mask for status
      if (a == addr_status) begin
        check_status(val, e, d);
      end else begin
        check_data(val, e);
      end
    end else if (op == "P") begin
      poll_status(a, d, e, ok);
      if (!ok) begin
        errors++;
        case_bad = 1'b1;
        abort    = 1'b1;
      end
    end else if (op == "I") begin
      // irq is a registered level, one clock behind the flags
      @(posedge clock);
      @(negedge clock);
      check_irq(irq, e[0]);
    end else begin
      $display("unknown operation %s in the case file", op);
      errors++;
      case_bad = 1'b1;
    end
    ncases++;
    if (case_bad) begin
      nfail++;
    end
    $display("case %0d: %s %h %h %h %s", ncases, op, a, d, e, case_bad ? "mismatch" : "ok");
  endtask

  initial begin : main
    string                 line;
    string                 op;
    int                    fd;
    int                    rc;
    logic [reg_word_w-1:0] a_col;
    logic [reg_word_w-1:0] d_col;
    logic [reg_word_w-1:0] e_col;
    seed     = 32'hd591;
    errors   = 0;
    ncases   = 0;
    nfail    = 0;
    abort    = 1'b0;
    case_bad = 1'b0;
    rst      = 1'b1;
    sel      = 1'b0;
    wr       = 1'b0;
    addr     = '0;
    wdata    = '0;
    loop_en  = 1'b0;
    repeat (16) @(posedge clock);
    rst     <= 1'b0;
    loop_en <= 1'b1;
    fd = $fopen("uart_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open uart_cases.txt for reading");
      errors++;
    end else begin
      while (!abort && !$feof(fd)) begin
        rc = $fgets(line, fd);
        // skip comments and blank lines
        if (rc == 0 || line.len() < 2 || line[0] == "#") begin
          continue;
        end
        rc = $sscanf(line, "%s %h %h %h", op, a_col, d_col, e_col);
        if (rc != 4) begin
          $display("case file line could not be parsed: %s", line);
          errors++;
          continue;
        end
        run_case(op, a_col[reg_addr_w-1:0], d_col, e_col);
      end
      $fclose(fd);
    end
    if (ncases == 0) begin
      $display("no cases were run");
      errors++;
    end
    $display("cases run %0d, cases with errors %0d, total errors %0d", ncases, nfail, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* uart_core.sv */
// UART peripheral top, joins the register block, TX and RX FIFOs and the two shifters
`timescale 1ns/1ns

module uart_core (
  input  logic                                clock,
  input  logic                                rst,
  input  logic                                sel,
  input  logic                                wr,
  input  logic [uart_reg_pkg::reg_addr_w-1:0] addr,
  input  logic [uart_reg_pkg::reg_word_w-1:0] wdata,
  input  logic                                rx,
  output logic [uart_reg_pkg::reg_word_w-1:0] rdata,
  output logic                                irq,
  output logic                                tx
);
  import uart_reg_pkg::*;
  import uart_fifo_pkg::*;

  // host to TX FIFO
  logic                    tx_push;
  logic [data_w-1:0]       tx_data;
  logic [fifo_level_w-1:0] tx_level;
  logic                    tx_empty;
  logic                    tx_full;
  logic                    tx_below;
  // TX FIFO to serializer
  logic [data_w-1:0]       tx_head;
  logic                    tx_pop;
  logic                    tx_busy;
  // deserializer to RX FIFO
  logic                    rx_push;
  logic [data_w-1:0]       rx_data;
  // RX FIFO to host
  logic                    rx_pop;
  logic [data_w-1:0]       rx_head;
  logic [fifo_level_w-1:0] rx_level;
  logic                    rx_empty;
  logic                    rx_full;
  logic                    rx_above;
  logic [7:0]              baud_div;

  uart_regs u_regs (
    .clock(clock), .rst(rst), .sel(sel), .wr(wr), .addr(addr), .wdata(wdata),
    .tx_empty(tx_empty), .tx_full(tx_full), .tx_below(tx_below), .tx_busy(tx_busy),
    .rx_head(rx_head), .rx_empty(rx_empty), .rx_full(rx_full), .rx_above(rx_above),
    .rdata(rdata), .tx_push(tx_push), .tx_data(tx_data), .rx_pop(rx_pop),
    .baud_div(baud_div), .tx_level(tx_level), .rx_level(rx_level), .irq(irq)
  );

  // above unused on the TX side
  sync_fifo u_tx_fifo (
    .clock(clock), .rst(rst), .push(tx_push), .pop(tx_pop), .push_data(tx_data),
    .level(tx_level), .head(tx_head), .empty(tx_empty), .full(tx_full),
    .below(tx_below), .above()
  );

  // below unused on the RX side
  sync_fifo u_rx_fifo (
    .clock(clock), .rst(rst), .push(rx_push), .pop(rx_pop), .push_data(rx_data),
    .level(rx_level), .head(rx_head), .empty(rx_empty), .full(rx_full),
    .below(), .above(rx_above)
  );

  uart_tx_shift u_tx_shift (
    .clock(clock), .rst(rst), .baud_div(baud_div), .fifo_empty(tx_empty),
    .fifo_head(tx_head), .fifo_pop(tx_pop), .busy(tx_busy), .tx(tx)
  );

  uart_rx_shift u_rx_shift (
    .clock(clock), .rst(rst), .baud_div(baud_div), .rx(rx),
    .push(rx_push), .push_data(rx_data)
  );

endmodule

/* uart_regs.sv */
// host register block, decodes strobes, holds configuration and reports FIFO status
`timescale 1ns/1ns

module uart_regs (
  input  logic                                   clock,
  input  logic                                   rst,
  input  logic                                   sel,
  input  logic                                   wr,
  input  logic [uart_reg_pkg::reg_addr_w-1:0]    addr,
  input  logic [uart_reg_pkg::reg_word_w-1:0]    wdata,
  input  logic                                   tx_empty,
  input  logic                                   tx_full,
  input  logic                                   tx_below,
  input  logic                                   tx_busy,
  input  logic [uart_reg_pkg::data_w-1:0]        rx_head,
  input  logic                                   rx_empty,
  input  logic                                   rx_full,
  input  logic                                   rx_above,
  output logic [uart_reg_pkg::reg_word_w-1:0]    rdata,
  output logic                                   tx_push,
  output logic [uart_reg_pkg::data_w-1:0]        tx_data,
  output logic                                   rx_pop,
  output logic [7:0]                             baud_div,
  output logic [uart_fifo_pkg::fifo_level_w-1:0] tx_level,
  output logic [uart_fifo_pkg::fifo_level_w-1:0] rx_level,
  output logic                                   irq
);
  import uart_reg_pkg::*;
  import uart_fifo_pkg::*;

  uart_word_u             wword;
  uart_word_u             cfg_q;
  logic [reg_word_w-1:0]  status;
  logic                   wr_stb;
  logic                   rd_stb;

  assign wword  = wdata;
  assign wr_stb = sel & wr;
  assign rd_stb = sel & ~wr;

  // data port strobes go straight to the FIFOs
  assign tx_push = wr_stb & (addr == addr_data);
  assign tx_data = wword.dat.data;
  assign rx_pop  = rd_stb & (addr == addr_data);

  // configuration storage
  always_ff @(posedge clock) begin
    if (rst) begin
      cfg_q <= '0;
    end else if (wr_stb && addr == addr_config) begin
      cfg_q <= wword;
    end
  end

  assign baud_div = cfg_q.cfg.baud_div;
  // 3-bit levels widened to the count width
  assign tx_level = fifo_level_w'(cfg_q.cfg.tx_level);
  assign rx_level = fifo_level_w'(cfg_q.cfg.rx_level);

  // status word, upper bits zero
  always_comb begin
    status              = '0;
    status[st_tx_empty] = tx_empty;
    status[st_tx_full]  = tx_full;
    status[st_tx_below] = tx_below;
    status[st_rx_empty] = rx_empty;
    status[st_rx_full]  = rx_full;
    status[st_rx_above] = rx_above;
    status[st_tx_busy]  = tx_busy;
  end

  // read data held until next read
  always_ff @(posedge clock) begin
    if (rst) begin
      rdata <= '0;
    end else if (rd_stb) begin
      case (addr)
        addr_data:   rdata <= rx_empty ? '0 : reg_word_w'(rx_head);
        addr_status: rdata <= status;
        addr_config: rdata <= cfg_q;
        default:     rdata <= '0;
      endcase
    end
  end

  // level interrupt, either watermark with its enable
  always_ff @(posedge clock) begin
    if (rst) begin
      irq <= 1'b0;
    end else begin
      irq <= (tx_below & cfg_q.cfg.tx_irq_en) | (rx_above & cfg_q.cfg.rx_irq_en);
    end
  end

endmodule

/* uart_rx_shift.sv */
// 8N1 receiver, samples the serial input and pushes good bytes into the RX FIFO
`timescale 1ns/1ns

module uart_rx_shift (
  input  logic                            clock,
  input  logic                            rst,
  input  logic [7:0]                      baud_div,
  input  logic                            rx,
  output logic                            push,
  output logic [uart_reg_pkg::data_w-1:0] push_data
);
  import uart_reg_pkg::*;

  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;
  logic [1:0]        state;
  logic [7:0]        cnt;
  logic [3:0]        bit_idx;
  logic [data_w-1:0] shift;
  logic [7:0]        half_div;

  // start check point, half a bit in
  assign half_div = {1'b0, baud_div[7:1]};

  // two-flop synchronizer plus edge history
  always_ff @(posedge clock) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state   <= rx_st_idle;
      cnt     <= '0;
      bit_idx <= '0;
      push    <= 1'b0;
    end else begin
      push <= 1'b0;
      case (state)
        rx_st_idle: begin
          // falling edge opens a frame
          if (rx_prev & ~rx_sync) begin
            state <= rx_st_start;
            cnt   <= '0;
          end
        end
        rx_st_start: begin
          if (cnt == half_div) begin
            cnt     <= '0;
            bit_idx <= '0;
            // glitch, not a start bit
            state   <= rx_sync ? rx_st_idle : rx_st_data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        rx_st_data: begin
          if (cnt == baud_div) begin
            cnt <= '0;
            if (bit_idx == 4'(data_w)) begin
              // stop bit, keep the byte only if high
              push  <= rx_sync;
              state <= rx_st_idle;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= rx_st_idle;
      endcase
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clock) begin
    if (state == rx_st_data && cnt == baud_div && bit_idx < 4'(data_w)) begin
      shift <= {rx_sync, shift[data_w-1:1]};
    end
  end

  // stable while push is high
  assign push_data = shift;

endmodule

/* uart_tx_shift.sv */
// 8N1 transmitter, pulls bytes from the TX FIFO and drives the serial line
`timescale 1ns/1ns

module uart_tx_shift (
  input  logic                            clock,
  input  logic                            rst,
  input  logic [7:0]                      baud_div,
  input  logic                            fifo_empty,
  input  logic [uart_reg_pkg::data_w-1:0] fifo_head,
  output logic                            fifo_pop,
  output logic                            busy,
  output logic                            tx
);
  import uart_reg_pkg::*;

  // stop, data, start
  logic [data_w+1:0] shift;
  logic [7:0]        baud_cnt;
  logic [3:0]        bit_idx;
  logic              bit_end;

  // pop in the same cycle as the load
  assign fifo_pop = ~busy & ~fifo_empty;

  // each bit lasts baud_div+1 clocks
  assign bit_end = (baud_cnt == baud_div);

  always_ff @(posedge clock) begin
    if (rst) begin
      // line idles high
      shift    <= '1;
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (fifo_pop) begin
      shift    <= {1'b1, fifo_head, 1'b0};
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        if (bit_idx == 4'(data_w + 1)) begin
          // stop bit done
          busy <= 1'b0;
        end else begin
          bit_idx <= bit_idx + 1'b1;
          // shift in ones so the line rests high
          shift   <= {1'b1, shift[data_w+1:1]};
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // lsb of the frame is the line
  assign tx = shift[0];

endmodule

/* sync_fifo.sv */
// byte FIFO with fall-through head, occupancy count and watermark flags, used for TX and RX
`timescale 1ns/1ns

module sync_fifo (
  input  logic                                clock,
  input  logic                                rst,
  input  logic                                push,
  input  logic                                pop,
  input  logic [uart_reg_pkg::data_w-1:0]     push_data,
  input  logic [uart_fifo_pkg::fifo_level_w-1:0] level,
  output logic [uart_reg_pkg::data_w-1:0]     head,
  output logic                                empty,
  output logic                                full,
  output logic                                below,
  output logic                                above
);
  import uart_reg_pkg::*;
  import uart_fifo_pkg::*;

  logic [data_w-1:0]       mem [fifo_depth];
  logic [fifo_ptr_w-1:0]   wr_ptr;
  logic [fifo_ptr_w-1:0]   rd_ptr;
  logic [fifo_level_w-1:0] count;
  logic                    do_push;
  logic                    do_pop;

  // strobes ignored when full or empty
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // storage
  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // fall-through read
  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == fifo_level_w'(fifo_depth));
  // watermark in both directions
  assign below = (count < level);
  assign above = (count > level);

endmodule

/* uart_reg_pkg.sv */
// host register map, status layout and word views, imported by the UART blocks and testbench
package uart_reg_pkg;

  // serial byte and host port widths
  localparam int data_w     = 8;
  localparam int reg_addr_w = 2;
  localparam int reg_word_w = 16;

  // register addresses
  // data is push on write, pop on read
  localparam logic [reg_addr_w-1:0] addr_data   = 2'd0;
  localparam logic [reg_addr_w-1:0] addr_status = 2'd1;
  localparam logic [reg_addr_w-1:0] addr_config = 2'd2;

  // status word bit positions
  localparam int st_tx_empty = 0;
  localparam int st_tx_full  = 1;
  localparam int st_tx_below = 2;
  localparam int st_rx_empty = 3;
  localparam int st_rx_full  = 4;
  localparam int st_rx_above = 5;
  localparam int st_tx_busy  = 6;

  // receiver states
  localparam logic [1:0] rx_st_idle  = 2'd0;
  localparam logic [1:0] rx_st_start = 2'd1;
  localparam logic [1:0] rx_st_data  = 2'd2;

  // configuration view, msb first
  typedef struct packed {
    logic [7:0] baud_div;
    logic [2:0] tx_level;
    logic [2:0] rx_level;
    logic       tx_irq_en;
    logic       rx_irq_en;
  } uart_cfg_t;

  // data view, byte in the low half
  typedef struct packed {
    logic [reg_word_w-data_w-1:0] pad;
    logic [data_w-1:0]            data;
  } uart_data_t;

  typedef union packed {
    uart_cfg_t  cfg;
    uart_data_t dat;
  } uart_word_u;

endpackage

/* uart_fifo_pkg.sv */
// FIFO sizing constants, imported by the FIFO and by blocks that program its levels
package uart_fifo_pkg;

  // entries per FIFO
  localparam int fifo_depth = 8;

  // read and write pointer width, wraps naturally at fifo_depth
  localparam int fifo_ptr_w = 3;

  // occupancy count width
  // one bit wider than the pointers so a full FIFO reads as 8
  localparam int fifo_level_w = 4;

endpackage
